// ==== source/cpuPkg.sv ====
package cpuPkg;

    // ##########################################################
    // basic word types
    // ##########################################################

    typedef logic [31:0] dataWord;   // register, ALU and memory value
    typedef logic [15:0] instrAddr;  // byte address into instruction memory
    typedef logic [4:0]  regIndex;

    // ##########################################################
    // instruction encodings
    // ##########################################################

    localparam logic [5:0] opR    = 6'h00;
    localparam logic [5:0] opJ    = 6'h02;
    localparam logic [5:0] opBeq  = 6'h04;
    localparam logic [5:0] opBne  = 6'h05;
    localparam logic [5:0] opAddi = 6'h08;
    localparam logic [5:0] opLw   = 6'h23;
    localparam logic [5:0] opSw   = 6'h2b;

    // R-type funct field
    localparam logic [5:0] fnAdd = 6'h20;
    localparam logic [5:0] fnSub = 6'h22;
    localparam logic [5:0] fnAnd = 6'h24;
    localparam logic [5:0] fnOr  = 6'h25;
    localparam logic [5:0] fnSlt = 6'h2a;

    // ##########################################################
    // datapath selects
    // ##########################################################

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOp;

    // where execute takes an operand from
    typedef enum logic [1:0] {
        fwdNone,  // value read in decode
        fwdMem,   // ALU result now in memory stage
        fwdWb     // value now in writeback
    } fwdSel;

    localparam instrAddr resetPc = 16'h0000;

endpackage

// ==== source/fetchStage.sv ====
`timescale 1ns/1ps

module fetchStage import cpuPkg::*; (
    input  logic     Clock,
    input  logic     nReset,
    input  logic     stall,
    input  logic     flush,
    input  logic     branchTaken,
    input  instrAddr branchTarget,
    input  dataWord  InstrMem,
    output instrAddr InstrAddr,
    output dataWord  instrD,
    output instrAddr pcD
);

    instrAddr pcNext;

    // a taken branch wins over a load-use hold
    always_comb begin
        if (branchTaken)
            pcNext = branchTarget;
        else if (stall)
            pcNext = InstrAddr;
        else
            pcNext = InstrAddr + 16'd4;
    end

    always_ff @(posedge Clock, negedge nReset) begin
        if (!nReset)
            InstrAddr <= resetPc;
        else
            InstrAddr <= pcNext;
    end

    // fetch/decode register, an all zero word decodes as a no-op
    always_ff @(posedge Clock, negedge nReset) begin
        if (!nReset) begin
            instrD <= '0;
            pcD    <= resetPc;
        end else if (flush) begin
            instrD <= '0;
            pcD    <= resetPc;
        end else if (!stall) begin
            instrD <= InstrMem;
            pcD    <= InstrAddr;
        end
    end

endmodule

// ==== source/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit import cpuPkg::*; (
    input  dataWord instrD,
    input  logic    branchTaken,
    input  logic    memReadE,
    input  logic    regWriteE,
    input  logic    regWriteM,
    input  logic    regWriteW,
    input  regIndex destE,
    input  regIndex destM,
    input  regIndex destW,
    output aluOp    aluCtl,
    output logic    aluSrcImm,
    output logic    memRead,
    output logic    memWrite,
    output logic    regWrite,
    output logic    memToReg,
    output logic    branch,
    output logic    branchNe,
    output logic    jump,
    output logic    useRt,
    output regIndex dest,
    output logic    stall,
    output logic    flush,
    output fwdSel   fwdA,
    output fwdSel   fwdB
);

    logic [5:0] opcode;
    logic [5:0] funct;
    regIndex    rs;
    regIndex    rt;
    regIndex    rd;
    logic       useRs;

    assign opcode = instrD[31:26];
    assign funct  = instrD[5:0];
    assign rs     = instrD[25:21];
    assign rt     = instrD[20:16];
    assign rd     = instrD[15:11];

    // ##########################################################
    // decoder
    // ##########################################################

    always_comb begin
        aluCtl    = aluAdd;
        aluSrcImm = 1'b0;
        memRead   = 1'b0;
        memWrite  = 1'b0;
        regWrite  = 1'b0;
        memToReg  = 1'b0;
        branch    = 1'b0;
        branchNe  = 1'b0;
        jump      = 1'b0;
        useRt     = 1'b0;
        dest      = rt;
        case (opcode)
            opR: begin
                useRt    = 1'b1;
                dest     = rd;
                regWrite = 1'b1;
                case (funct)
                    fnAdd:   aluCtl = aluAdd;
                    fnSub:   aluCtl = aluSub;
                    fnAnd:   aluCtl = aluAnd;
                    fnOr:    aluCtl = aluOr;
                    fnSlt:   aluCtl = aluSlt;
                    default: regWrite = 1'b0;  // includes the all zero no-op
                endcase
            end
            opAddi: begin
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
            end
            opLw: begin
                aluSrcImm = 1'b1;
                memRead   = 1'b1;
                memToReg  = 1'b1;
                regWrite  = 1'b1;
            end
            opSw: begin
                aluSrcImm = 1'b1;
                memWrite  = 1'b1;
                useRt     = 1'b1;  // store data
            end
            opBeq, opBne: begin
                aluCtl   = aluSub;
                branch   = 1'b1;
                branchNe = (opcode == opBne);
                useRt    = 1'b1;
            end
            opJ: jump = 1'b1;
            default: ;
        endcase
    end

    assign useRs = !jump;  // J carries its target in the rs field

    // ##########################################################
    // hazards and forwarding
    // ##########################################################

    // load in execute feeding the instruction in decode
    assign stall = memReadE && regWriteE && destE != '0
                && ((useRs && destE == rs) || (useRt && destE == rt));

    assign flush = branchTaken;

    // chosen here and applied one stage later when the operands are in execute
    // a producer already in writeback is covered by the register file bypass
    function automatic fwdSel pickFwd(input regIndex src);
        fwdSel sel;
        if (src == '0)
            sel = fwdNone;
        else if (regWriteE && destE == src)
            sel = fwdMem;
        else if (regWriteM && destM == src)
            sel = fwdWb;
        else
            sel = fwdNone;
        return sel;
    endfunction

    assign fwdA = useRs ? pickFwd(rs) : fwdNone;
    assign fwdB = useRt ? pickFwd(rt) : fwdNone;

endmodule

// ==== source/decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage import cpuPkg::*; (
    input  logic     Clock,
    input  logic     nReset,
    input  dataWord  instrD,
    input  instrAddr pcD,
    input  aluOp     aluCtl,
    input  logic     aluSrcImm,
    input  logic     memRead,
    input  logic     memWrite,
    input  logic     regWrite,
    input  logic     memToReg,
    input  logic     branch,
    input  logic     branchNe,
    input  logic     jump,
    input  logic     useRt,
    input  regIndex  dest,
    input  fwdSel    fwdA,
    input  fwdSel    fwdB,
    input  logic     stall,
    input  logic     flush,
    input  dataWord  wbData,
    input  regIndex  wbDest,
    input  logic     wbWrite,
    input  regIndex  RegAddr,
    output dataWord  RegData,
    output dataWord  rsValE,
    output dataWord  rtValE,
    output dataWord  immE,
    output instrAddr pcE,
    output dataWord  offsetE,
    output aluOp     aluCtlE,
    output logic     aluSrcImmE,
    output logic     memReadE,
    output logic     memWriteE,
    output logic     regWriteE,
    output logic     memToRegE,
    output logic     branchE,
    output logic     branchNeE,
    output logic     jumpE,
    output regIndex  destE,
    output fwdSel    fwdAE,
    output fwdSel    fwdBE
);

    dataWord regs [32];
    dataWord immExt;
    dataWord offsetVal;
    logic    bubble;

    // ##########################################################
    // register file
    // ##########################################################

    always_ff @(posedge Clock, negedge nReset) begin
        if (!nReset) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wbWrite && wbDest != '0) begin
            regs[wbDest] <= wbData;
        end
    end

    // write-through so decode sees the value retiring this cycle
    function automatic dataWord readReg(input regIndex idx);
        dataWord val;
        if (idx == '0)
            val = '0;
        else if (wbWrite && wbDest == idx)
            val = wbData;
        else
            val = regs[idx];
        return val;
    endfunction

    assign RegData = regs[RegAddr];  // debug read

    assign immExt    = {{16{instrD[15]}}, instrD[15:0]};
    assign offsetVal = jump ? {6'b0, instrD[25:0]} : immExt;  // word index for J
    assign bubble    = stall || flush;

    // ##########################################################
    // decode/execute register
    // ##########################################################

    always_ff @(posedge Clock, negedge nReset) begin
        if (!nReset) begin
            aluCtlE    <= aluAdd;
            aluSrcImmE <= 1'b0;
            memReadE   <= 1'b0;
            memWriteE  <= 1'b0;
            regWriteE  <= 1'b0;
            memToRegE  <= 1'b0;
            branchE    <= 1'b0;
            branchNeE  <= 1'b0;
            jumpE      <= 1'b0;
            destE      <= '0;
            fwdAE      <= fwdNone;
            fwdBE      <= fwdNone;
        end else begin
            aluCtlE    <= aluCtl;
            aluSrcImmE <= aluSrcImm;
            memReadE   <= memRead && !bubble;
            memWriteE  <= memWrite && !bubble;
            regWriteE  <= regWrite && !bubble;
            memToRegE  <= memToReg;
            branchE    <= branch && !bubble;
            branchNeE  <= branchNe;
            jumpE      <= jump && !bubble;
            destE      <= dest;
            fwdAE      <= fwdA;
            fwdBE      <= fwdB;
        end
    end

    always_ff @(posedge Clock) begin
        rsValE  <= readReg(instrD[25:21]);
        rtValE  <= useRt ? readReg(instrD[20:16]) : '0;  // quiet when rt is a destination
        immE    <= immExt;
        pcE     <= pcD;
        offsetE <= offsetVal;
    end

endmodule

// ==== source/executeStage.sv ====
`timescale 1ns/1ps

module executeStage import cpuPkg::*; (
    input  logic     Clock,
    input  logic     nReset,
    input  dataWord  rsValE,
    input  dataWord  rtValE,
    input  dataWord  immE,
    input  instrAddr pcE,
    input  dataWord  offsetE,
    input  aluOp     aluCtlE,
    input  logic     aluSrcImmE,
    input  logic     memReadE,
    input  logic     memWriteE,
    input  logic     regWriteE,
    input  logic     memToRegE,
    input  logic     branchE,
    input  logic     branchNeE,
    input  logic     jumpE,
    input  regIndex  destE,
    input  fwdSel    fwdAE,
    input  fwdSel    fwdBE,
    input  dataWord  memFwd,
    input  dataWord  wbFwd,
    output logic     branchTaken,
    output instrAddr branchTarget,
    output dataWord  aluResM,
    output dataWord  storeM,
    output regIndex  destM,
    output logic     memReadM,
    output logic     memWriteM,
    output logic     regWriteM,
    output logic     memToRegM
);

    dataWord  opA;
    dataWord  opB;
    dataWord  aluIn2;
    dataWord  aluRes;
    instrAddr pcPlus4;
    instrAddr offsetBytes;

    function automatic dataWord fwdMux(input fwdSel sel, input dataWord regVal);
        dataWord val;
        case (sel)
            fwdMem:  val = memFwd;
            fwdWb:   val = wbFwd;
            default: val = regVal;
        endcase
        return val;
    endfunction

    assign opA    = fwdMux(fwdAE, rsValE);
    assign opB    = fwdMux(fwdBE, rtValE);  // also the store data
    assign aluIn2 = aluSrcImmE ? immE : opB;

    // ##########################################################
    // ALU
    // ##########################################################

    always_comb begin
        case (aluCtlE)
            aluSub:  aluRes = opA - aluIn2;
            aluAnd:  aluRes = opA & aluIn2;
            aluOr:   aluRes = opA | aluIn2;
            aluSlt:  aluRes = dataWord'($signed(opA) < $signed(aluIn2));
            default: aluRes = opA + aluIn2;
        endcase
    end

    // branch decision and target
    assign branchTaken  = jumpE || (branchE && ((opA == opB) != branchNeE));
    assign pcPlus4      = pcE + 16'd4;
    assign offsetBytes  = {offsetE[13:0], 2'b00};
    assign branchTarget = jumpE ? offsetBytes : pcPlus4 + offsetBytes;

    // execute/memory register
    always_ff @(posedge Clock, negedge nReset) begin
        if (!nReset) begin
            destM     <= '0;
            memReadM  <= 1'b0;
            memWriteM <= 1'b0;
            regWriteM <= 1'b0;
            memToRegM <= 1'b0;
        end else begin
            destM     <= destE;
            memReadM  <= memReadE;
            memWriteM <= memWriteE;
            regWriteM <= regWriteE;
            memToRegM <= memToRegE;
        end
    end

    always_ff @(posedge Clock) begin
        aluResM <= aluRes;
        storeM  <= opB;
    end

endmodule

// ==== source/memoryStage.sv ====
`timescale 1ns/1ps

module memoryStage import cpuPkg::*; (
    input  logic    Clock,
    input  logic    nReset,
    input  dataWord aluResM,
    input  dataWord storeM,
    input  regIndex destM,
    input  logic    memReadM,
    input  logic    memWriteM,
    input  logic    regWriteM,
    input  logic    memToRegM,
    input  dataWord MemData,
    output dataWord MemAddr,
    output dataWord WriteData,
    output logic    MemWrite,
    output logic    MemRead,
    output dataWord wbData,
    output regIndex wbDest,
    output logic    wbWrite,
    output dataWord memFwd
);

    dataWord result;

    // data memory port, read data comes back in the same cycle
    assign MemAddr   = aluResM;
    assign WriteData = storeM;
    assign MemWrite  = memWriteM;
    assign MemRead   = memReadM;

    assign memFwd = aluResM;  // loads never forward from here, decode stalls them
    assign result = memToRegM ? MemData : aluResM;

    // memory/writeback register
    always_ff @(posedge Clock, negedge nReset) begin
        if (!nReset) begin
            wbDest  <= '0;
            wbWrite <= 1'b0;
        end else begin
            wbDest  <= destM;
            wbWrite <= regWriteM;
        end
    end

    always_ff @(posedge Clock)
        wbData <= result;

endmodule

// ==== source/processor.sv ====
`timescale 1ns/1ps

module processor import cpuPkg::*; (
    input  logic     Clock,
    input  logic     nReset,
    input  dataWord  InstrMem,
    input  dataWord  MemData,
    input  regIndex  RegAddr,
    output instrAddr InstrAddr,
    output dataWord  MemAddr,
    output dataWord  WriteData,
    output logic     MemWrite,
    output logic     MemRead,
    output dataWord  RegData,
    output logic     nStall
);

    // ##########################################################
    // stage wiring named after the driving stage
    // ##########################################################

    dataWord  instrD;
    instrAddr pcD;
    aluOp     aluCtl;
    logic     aluSrcImm, memRead, memWrite, regWrite;
    logic     memToReg, branch, branchNe, jump, useRt;
    regIndex  dest;
    logic     stall, flush;
    fwdSel    fwdA, fwdB;

    dataWord  rsValE, rtValE, immE, offsetE;
    instrAddr pcE;
    aluOp     aluCtlE;
    logic     aluSrcImmE, memReadE, memWriteE, regWriteE, memToRegE;
    logic     branchE, branchNeE, jumpE;
    regIndex  destE;
    fwdSel    fwdAE, fwdBE;

    logic     branchTaken;
    instrAddr branchTarget;
    dataWord  aluResM, storeM;
    regIndex  destM;
    logic     memReadM, memWriteM, regWriteM, memToRegM;

    dataWord  wbData, memFwd;
    regIndex  wbDest;
    logic     wbWrite;

    assign nStall = !stall;

    fetchStage fetch0 (.*);

    controlUnit ctrl0 (
        .*,
        .destW    (wbDest),
        .regWriteW(wbWrite)
    );

    decodeStage dec0 (.*);

    executeStage ex0 (
        .*,
        .wbFwd(wbData)
    );

    memoryStage mem0 (.*);

endmodule

// ==== sim/clockGen.sv ====
`timescale 1ns/1ps

module clockGen #(
    parameter int resetCycles = 16
) (
    output logic Clock,
    output logic nReset
);

    initial begin
        Clock = 1'b0;
        forever #10 Clock = ~Clock;  // 20 ns period
    end

    // released on a falling edge, away from the sampling edge
    initial begin
        nReset = 1'b0;
        repeat (resetCycles) @(posedge Clock);
        @(negedge Clock);
        nReset = 1'b1;
    end

endmodule

// ==== sim/processorTb.sv ====
`timescale 1ns/1ps

module processorTb import cpuPkg::*; ();

    localparam int       resetCycles    = 16;
    localparam int       prefixLen      = 4;
    localparam int       numRandom      = 40;
    localparam int       haltIndex      = prefixLen + numRandom;
    localparam instrAddr haltAddr       = instrAddr'(haltIndex * 4);
    localparam int       haltVisits     = 10;
    localparam int       watchdogCycles = numRandom * 8 + resetCycles;

    logic     Clock;
    logic     nReset;
    dataWord  InstrMem;
    dataWord  MemData;
    regIndex  RegAddr;
    instrAddr InstrAddr;
    dataWord  MemAddr;
    dataWord  WriteData;
    logic     MemWrite;
    logic     MemRead;
    dataWord  RegData;
    logic     nStall;

    dataWord  imem [64];
    dataWord  dmem [64];
    dataWord  modelMem [64];
    dataWord  modelRegs [32];
    dataWord  storeAddrQ [$];
    dataWord  storeDataQ [$];
    instrAddr expFetch [$];   // model fetch order with flushed slots included
    instrAddr actFetch [$];

    int   seed       = 0;
    int   passCount  = 0;
    int   failCount  = 0;
    int   seenStores = 0;
    int   haltCount  = 0;
    logic sawStall   = 1'b0;

    clockGen #(.resetCycles(resetCycles)) clk0 (.Clock, .nReset);

    processor DUT (.*);

    // memories answer in the same cycle
    assign InstrMem = imem[InstrAddr[7:2]];
    assign MemData  = MemRead ? dmem[MemAddr[7:2]] : '0;

    always @(posedge Clock) begin
        if (MemWrite)
            dmem[MemAddr[7:2]] <= WriteData;
    end

    // ############################################################
    // checks
    // ############################################################

    task automatic checkWord(input string name, input dataWord expected, input dataWord actual);
        if (actual === expected) begin
            passCount++;
            $display("[PASS] %s", name);
        end else begin
            failCount++;
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic checkAddr(input string name, input instrAddr expected, input instrAddr actual);
        if (actual === expected) begin
            passCount++;
            $display("[PASS] %s", name);
        end else begin
            failCount++;
            $display("[FAIL] %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic reportError(input string what);
        failCount++;
        $display("ERROR: %s", what);
    endtask

    task automatic checkStore();
        if (seenStores < storeAddrQ.size()) begin
            checkWord($sformatf("store%0d address", seenStores), storeAddrQ[seenStores], MemAddr);
            checkWord($sformatf("store%0d data", seenStores), storeDataQ[seenStores], WriteData);
        end else begin
            reportError($sformatf("store to %h has no matching store in the model", MemAddr));
        end
        seenStores++;
    endtask

    // sampled mid-cycle once everything has settled
    always @(negedge Clock) begin
        if (nReset) begin
            if (nStall)
                actFetch.push_back(InstrAddr);
            else
                sawStall = 1'b1;
            if (InstrAddr == haltAddr)
                haltCount++;
            if (MemWrite)
                checkStore();
        end
    end

    // ############################################################
    // program generator and reference model
    // ############################################################

    function automatic int randBelow(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic regIndex randReg();
        return regIndex'(1 + randBelow(7));
    endfunction

    // initial data memory contents, different in every word
    function automatic dataWord fillWord(input int idx);
        return 32'hd000_0000 + idx * 32'h0001_0203;
    endfunction

    function automatic dataWord encR(input logic [5:0] fn, input regIndex rd,
                                     input regIndex rs, input regIndex rt);
        return {opR, rs, rt, rd, 5'b0, fn};
    endfunction

    function automatic dataWord encI(input logic [5:0] op, input regIndex rs,
                                     input regIndex rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic dataWord encJ(input int index);
        return {opJ, 26'(index)};
    endfunction

    task automatic buildProgram();
        int skip;
        for (int i = 0; i < 64; i++) begin
            imem[i] = '0;
            dmem[i] <= fillWord(i);
        end
        // load directly followed by its user
        imem[0] = encI(opAddi, 5'd0, 5'd1, 16'd12);
        imem[1] = encI(opSw, 5'd0, 5'd1, 16'd4);
        imem[2] = encI(opLw, 5'd0, 5'd2, 16'd4);
        imem[3] = encR(fnAdd, 5'd8, 5'd2, 5'd1);
        for (int i = prefixLen; i < haltIndex; i++) begin
            skip = randBelow(4);
            if (i + 1 + skip > haltIndex)
                skip = haltIndex - i - 1;  // forward only and never past halt
            case (randBelow(12))
                0:       imem[i] = encR(fnAdd, randReg(), randReg(), randReg());
                1:       imem[i] = encR(fnSub, randReg(), randReg(), randReg());
                2:       imem[i] = encR(fnAnd, randReg(), randReg(), randReg());
                3:       imem[i] = encR(fnOr, randReg(), randReg(), randReg());
                4:       imem[i] = encR(fnSlt, randReg(), randReg(), randReg());
                5, 6:    imem[i] = encI(opAddi, randReg(), randReg(), 16'(randBelow(16) - 8));
                7:       imem[i] = encI(opLw, 5'd0, randReg(), 16'(4 * randBelow(64)));
                8:       imem[i] = encI(opSw, 5'd0, randReg(), 16'(4 * randBelow(64)));
                9, 10:   imem[i] = encI(randBelow(2) == 0 ? opBeq : opBne,
                                        randReg(), randReg(), 16'(skip));
                default: imem[i] = encJ(i + 1 + skip);
            endcase
        end
        imem[haltIndex] = encJ(haltIndex);  // self-jump
    endtask

    function automatic void setReg(input regIndex idx, input dataWord val);
        if (idx != '0)
            modelRegs[idx] = val;
    endfunction

    task automatic runModel();
        instrAddr pc;
        instrAddr target;
        dataWord  ins;
        dataWord  a;
        dataWord  b;
        dataWord  imm;
        dataWord  addr;
        logic     taken;
        int       steps;
        for (int i = 0; i < 32; i++)
            modelRegs[i] = '0;
        for (int i = 0; i < 64; i++)
            modelMem[i] = fillWord(i);
        pc = resetPc;
        steps = 0;
        while (pc != haltAddr && steps < 1000) begin
            ins    = imem[pc[7:2]];
            a      = modelRegs[ins[25:21]];
            b      = modelRegs[ins[20:16]];
            imm    = {{16{ins[15]}}, ins[15:0]};
            addr   = a + imm;
            taken  = 1'b0;
            target = pc + 16'd4 + {imm[13:0], 2'b00};
            expFetch.push_back(pc);
            case (ins[31:26])
                opR: begin
                    case (ins[5:0])
                        fnAdd:   setReg(ins[15:11], a + b);
                        fnSub:   setReg(ins[15:11], a - b);
                        fnAnd:   setReg(ins[15:11], a & b);
                        fnOr:    setReg(ins[15:11], a | b);
                        fnSlt:   setReg(ins[15:11], ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                        default: ;
                    endcase
                end
                opAddi: setReg(ins[20:16], addr);
                opLw:   setReg(ins[20:16], modelMem[addr[7:2]]);
                opSw: begin
                    modelMem[addr[7:2]] = b;
                    storeAddrQ.push_back(addr);
                    storeDataQ.push_back(b);
                end
                opBeq: taken = (a == b);
                opBne: taken = (a != b);
                opJ: begin
                    taken  = 1'b1;
                    target = {ins[13:0], 2'b00};
                end
                default: ;
            endcase
            if (taken) begin
                expFetch.push_back(pc + 16'd4);  // the two discarded fetches
                expFetch.push_back(pc + 16'd8);
                pc = target;
            end else begin
                pc = pc + 16'd4;
            end
            steps++;
        end
        expFetch.push_back(pc);
        if (pc != haltAddr)
            reportError("reference model never reached the halt address");
    endtask

    task automatic readDebugReg(input regIndex idx, output dataWord val);
        @(posedge Clock);
        RegAddr <= idx;
        @(negedge Clock);
        val = RegData;
    endtask

    // ############################################################
    // test sequence
    // ############################################################

    initial begin
        dataWord regVal;
        int      mismatch;
        RegAddr <= '0;
        seed = 32'hc42;
        buildProgram();
        runModel();

        repeat (4) @(negedge Clock);
        checkAddr("resetPc during reset", resetPc, InstrAddr);
        checkWord("reset flags during reset", 32'h1, {29'b0, MemWrite, MemRead, nStall});
        @(posedge nReset);
        #1;
        checkAddr("resetPc after reset", resetPc, InstrAddr);
        checkWord("reset flags after reset", 32'h1, {29'b0, MemWrite, MemRead, nStall});

        wait (haltCount >= haltVisits);  // pipeline has drained by now

        for (int r = 0; r < 8; r++) begin
            readDebugReg(regIndex'(r), regVal);
            checkWord($sformatf("reg%0d", r), modelRegs[r], regVal);
        end
        readDebugReg(5'd8, regVal);
        checkWord("loadUseResult", modelRegs[8], regVal);
        checkWord("loadUseStall", 32'd1, {31'b0, sawStall});
        checkWord("storeCount", dataWord'(storeAddrQ.size()), dataWord'(seenStores));

        mismatch = -1;
        for (int k = 0; k < expFetch.size(); k++) begin
            if (mismatch < 0 && (k >= actFetch.size() || actFetch[k] != expFetch[k]))
                mismatch = k;
        end
        if (mismatch < 0)
            checkAddr("fetchOrder", haltAddr, actFetch[expFetch.size() - 1]);
        else if (mismatch < actFetch.size())
            checkAddr($sformatf("fetchOrder slot%0d", mismatch),
                      expFetch[mismatch], actFetch[mismatch]);
        else
            reportError("fetch stream ended before the model reached halt");

        $display("%0d checks passed, %0d failed", passCount, failCount);
        if (failCount == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    // watchdog sized from the program length
    initial begin
        repeat (watchdogCycles) @(posedge Clock);
        $display("ERROR: timeout, the program never reached its halt address");
        $display("tests failed");
        $finish;
    end

endmodule

// ==== build.f ====
source/cpuPkg.sv
source/fetchStage.sv
source/controlUnit.sv
source/decodeStage.sv
source/executeStage.sv
source/memoryStage.sv
source/processor.sv
sim/clockGen.sv
sim/processorTb.sv

// ==== run.sh ====
#!/bin/sh
# builds the processor testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f build.f --top-module processorTb -o processorSim

./obj_dir/processorSim | tee sim.log

if grep -q "all tests passed" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
